// File: sim.f
src/adc_pkg.sv
src/adc_cmd_if.sv
src/adc_reg_bank.sv
src/adc_serial_engine.sv
src/adc_rate_decimator.sv
src/adc_sample_stream.sv
src/adc_control_top.sv
dv/adc_chip_model.sv
dv/adc_control_props.sv
dv/adc_control_tb.sv

// File: Bender.yml
package:
  name: adc_control

sources:
  - files:
      - src/adc_pkg.sv
      - src/adc_cmd_if.sv
      - src/adc_reg_bank.sv
      - src/adc_serial_engine.sv
      - src/adc_rate_decimator.sv
      - src/adc_sample_stream.sv
      - src/adc_control_top.sv
  - target: test
    files:
      - dv/adc_chip_model.sv
      - dv/adc_control_props.sv
      - dv/adc_control_tb.sv

// File: dv/adc_control_tb.sv
// Testbench for the ADC control top with a behavioral ADC
// Bus tasks drive stimulus, immediate assertions check the responses
`timescale 1ns/10ps
`default_nettype none

module adc_control_tb;

  localparam int OFF_CHAN = 5;
  localparam int FREE_FRAMES = 100;
  localparam int HOLD_FRAMES = 20;
  // Clocks per frame plus gap: 17 sclk periods of 2*(divide+1) clocks
  localparam int FRAME_CLKS_FAST = 34;
  localparam int FRAME_CLKS_SLOW = 136;
  localparam int FAST_FRAMES = FREE_FRAMES + HOLD_FRAMES + 10;
  localparam int SLOW_FRAMES = 6;
  localparam int CYCLE_LIMIT =
      2 * (FAST_FRAMES * FRAME_CLKS_FAST + SLOW_FRAMES * FRAME_CLKS_SLOW) + 2000;

  logic clk;
  logic reset;
  adc_pkg::addr_t addr;
  adc_pkg::cmd_t data_in;
  logic enable;
  logic re;
  logic wr;
  adc_pkg::word_t data_out;
  logic sample_valid;
  adc_pkg::chan_t sample_chan;
  logic [31:0] sample_data;
  logic sample_credit;
  logic adc_sclk;
  logic cs;
  logic adc_din;
  logic adc_dout;
  adc_pkg::word_t chip_word;

  logic [31:0] rand_state;
  logic [31:0] rnd;
  int cycle;
  int mismatches;
  int failures;
  int owed;
  int credit_delay;
  int held_count;
  int gap_sum;
  int total_streamed;
  logic hold_credits;
  logic allow_gaps;
  logic was_read;
  adc_pkg::seq_t last_seq [adc_pkg::NUM_CHANNELS];
  adc_pkg::word_t last_word [adc_pkg::NUM_CHANNELS];
  adc_pkg::word_t v;
  int t0;
  int rises;

  adc_control_top DUT (
    .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .enable(enable),
    .re(re), .wr(wr), .data_out(data_out), .sample_valid(sample_valid),
    .sample_chan(sample_chan), .sample_data(sample_data),
    .sample_credit(sample_credit), .adc_sclk(adc_sclk), .cs(cs),
    .adc_din(adc_din), .adc_dout(adc_dout)
  );

  adc_chip_model chip (
    .adc_sclk(adc_sclk), .cs(cs), .adc_din(adc_din), .adc_dout(adc_dout),
    .next_word(chip_word)
  );

  bind adc_control_top adc_control_props u_props (
    .clk(clk), .reset(reset), .cs(cs), .adc_din(adc_din), .adc_sclk(adc_sclk),
    .sample_valid(sample_valid), .sample_credit(sample_credit), .divide(cmd.divide)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // ------------------------------------------------
  // Clock, cycle limit and the word for the next frame
  // ------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    was_read <= enable && re;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles", cycle);
      $display("sim failed");
      $finish;
    end
  end

  always @(posedge cs) begin
    rnd = next_rand();
    chip_word = rnd[15:0];
  end

  // ------------------------------------------------
  // Bus tasks, all driving on the falling edge
  // ------------------------------------------------
  task automatic write_reg(input adc_pkg::reg_sel_t sel, input logic [7:0] chan,
                           input adc_pkg::cmd_t data);
    @(negedge clk);
    addr = {chan, 4'h0, sel};
    data_in = data;
    enable = 1'b1;
    wr = 1'b1;
    @(negedge clk);
    enable = 1'b0;
    wr = 1'b0;
  endtask

  task automatic read_reg(input adc_pkg::reg_sel_t sel, input logic [7:0] chan,
                          output adc_pkg::word_t val);
    @(negedge clk);
    addr = {chan, 4'h0, sel};
    enable = 1'b1;
    re = 1'b1;
    @(negedge clk);
    enable = 1'b0;
    re = 1'b0;
    val = data_out;
  endtask

  task automatic wait_idle();
    adc_pkg::word_t b;
    do begin
      read_reg(adc_pkg::REG_BUSY, 8'd0, b);
    end while (b != '0);
  endtask

  // Random interval per channel, one channel kept off
  task automatic set_rates(input int base, input int span);
    logic [31:0] r;
    for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
      r = next_rand();
      write_reg(adc_pkg::REG_OVERFLOW, 8'(c),
                (c == OFF_CHAN) ? 32'd0 : 32'(base + int'(r[15:0]) % span));
    end
  endtask

  task automatic stop_rates();
    for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
      write_reg(adc_pkg::REG_OVERFLOW, 8'(c), 32'd0);
    end
  endtask

  task automatic drain();
    repeat (20) @(negedge clk);
    while (owed != 0) @(negedge clk);
    repeat (10) @(negedge clk);
  endtask

  // ------------------------------------------------
  // Stream monitor and credit return
  // ------------------------------------------------
  task automatic take_sample();
    adc_pkg::chan_t c;
    adc_pkg::seq_t s;
    adc_pkg::word_t w;
    c = sample_chan;
    s = sample_data[31:16];
    w = sample_data[15:0];
    owed++;
    total_streamed++;
    if (hold_credits) held_count++;
    check_value("sample_chan", 32'(c), 32'(w[15:13]));
    assert (chip.sent_map[w]) else begin
      failures++;
      $display("sample word %h was never sent by the ADC model", w);
    end
    assert (c != OFF_CHAN) else begin
      failures++;
      $display("sample streamed on a channel with overflow 0");
    end
    if (allow_gaps) begin
      gap_sum += int'(s) - int'(last_seq[c]) - 1;
    end else begin
      check_value("sample_seq", 32'(s), 32'(last_seq[c] + 1'b1));
    end
    last_seq[c] = s;
    last_word[c] = w;
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      // Idle bus cycles return zero
      if (!was_read) check_value("data_out", 32'(data_out), 32'd0);
      if (sample_valid) take_sample();
      if (credit_delay > 0) credit_delay--;
      sample_credit = 1'b0;
      if (!hold_credits && owed > 0 && credit_delay == 0) begin
        sample_credit = 1'b1;
        owed--;
        rnd = next_rand();
        credit_delay = int'(rnd[1:0]);
      end
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  initial begin
    rand_state = 32'h6ee119fb;
    reset = 1'b1;
    addr = '0;
    data_in = '0;
    enable = 1'b0;
    re = 1'b0;
    wr = 1'b0;
    sample_credit = 1'b0;
    chip_word = 16'h2000;
    cycle = 0;
    mismatches = 0;
    failures = 0;
    owed = 0;
    credit_delay = 0;
    held_count = 0;
    gap_sum = 0;
    total_streamed = 0;
    hold_credits = 1'b0;
    allow_gaps = 1'b0;
    was_read = 1'b0;
    for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
      last_seq[c] = '0;
      last_word[c] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // ID and channels past the last one
    read_reg(adc_pkg::REG_ID, 8'd0, v);
    check_value("data_out", 32'(v), 32'h0ADC);
    read_reg(adc_pkg::REG_ID, 8'd8, v);
    check_value("data_out", 32'(v), 32'd0);
    read_reg(adc_pkg::REG_ID, 8'hFF, v);
    check_value("data_out", 32'(v), 32'd0);

    // Program frame
    write_reg(adc_pkg::REG_PROGRAM, 8'd0, {16'h0001, 16'hA5C3});
    wait_idle();
    check_value("adc_din", 32'(chip.rx_last), 32'hA5C3);
    read_reg(adc_pkg::REG_LAST, 8'd0, v);
    check_value("last_cmd", 32'(v), 32'hA5C3);

    // Free-running stream, then read-back of the newest samples
    set_rates(64, 128);
    repeat (FREE_FRAMES * FRAME_CLKS_FAST) @(negedge clk);
    stop_rates();
    drain();
    for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
      read_reg(adc_pkg::REG_SAMPLE, 8'(c), v);
      check_value("rd_sample", 32'(v), 32'(last_word[c]));
      read_reg(adc_pkg::REG_SEQUENCE, 8'(c), v);
      check_value("rd_seq", 32'(v), 32'(last_seq[c]));
    end
    assert (total_streamed > 0) else begin
      failures++;
      $display("no samples were streamed");
    end

    // Credits withheld, drops show up as sequence gaps
    hold_credits = 1'b1;
    allow_gaps = 1'b1;
    set_rates(16, 16);
    repeat (HOLD_FRAMES * FRAME_CLKS_FAST) @(negedge clk);
    check_value("sample_valid count", 32'(held_count), 32'(adc_pkg::SAMPLE_CREDITS));
    stop_rates();
    hold_credits = 1'b0;
    drain();
    for (int c = 0; c < adc_pkg::NUM_CHANNELS; c++) begin
      // Drops after the last delivered sample
      read_reg(adc_pkg::REG_SEQUENCE, 8'(c), v);
      gap_sum += int'(v) - int'(last_seq[c]);
    end
    read_reg(adc_pkg::REG_DROPS, 8'd0, v);
    check_value("drops", 32'(v), 32'(gap_sum));
    assert (gap_sum > 0) else begin
      failures++;
      $display("no samples dropped under back-pressure");
    end

    // Slower serial clock
    write_reg(adc_pkg::REG_DIVIDE, 8'd0, 32'd3);
    @(posedge cs);
    @(posedge cs);
    @(posedge adc_sclk);
    t0 = cycle;
    @(posedge adc_sclk);
    check_value("adc_sclk period", 32'(cycle - t0), 32'd8);
    @(negedge cs);
    t0 = cycle;
    rises = 0;
    while (cs == 1'b0) begin
      @(posedge adc_sclk or posedge cs);
      if (!cs) rises++;
    end
    check_value("adc_sclk rises", 32'(rises), 32'(adc_pkg::FRAME_BITS));
    check_value("cs low cycles", 32'(cycle - t0), 32'd128);
    write_reg(adc_pkg::REG_PROGRAM, 8'd0, {16'h0001, 16'h3C5A});
    wait_idle();
    check_value("adc_din", 32'(chip.rx_last), 32'h3C5A);

    repeat (5) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures, %0d property failures",
             mismatches, failures, DUT.u_props.fails);
    if (mismatches == 0 && failures == 0 && DUT.u_props.fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/adc_control_props.sv
// Concurrent checks on the ADC control top, attached with bind
`timescale 1ns/10ps
`default_nettype none

module adc_control_props (
  input logic clk,
  input logic reset,
  input logic cs,
  input logic adc_din,
  input logic adc_sclk,
  input logic sample_valid,
  input logic sample_credit,
  input adc_pkg::word_t divide
);

  int outstanding;
  // Number of failed properties
  int fails = 0;
  logic sclk_q;
  adc_pkg::word_t div_q;
  logic [16:0] held;
  logic run_ok;

  // Samples delivered but not yet credited back
  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(sample_valid) - int'(sample_credit);
    end
  end

  // Length of the current sclk level, run_ok while divide stayed put
  always_ff @(posedge clk) begin
    sclk_q <= adc_sclk;
    div_q <= divide;
    if (reset) begin
      held <= '0;
      run_ok <= 1'b0;
    end else if (adc_sclk != sclk_q) begin
      held <= 17'd1;
      run_ok <= (divide == div_q);
    end else begin
      held <= held + 1'b1;
      if (divide != div_q) begin
        run_ok <= 1'b0;
      end
    end
  end

  // ------------------------------------------------
  a_cs_after_reset: assert property (@(posedge clk) reset |=> cs)
    else begin
      fails++;
      $error("cs low right after reset");
    end

  a_din_idle: assert property (@(posedge clk) disable iff (reset) cs |-> !adc_din)
    else begin
      fails++;
      $error("din high outside a frame");
    end

  // din moves only together with a falling sclk edge
  a_din_on_fall: assert property (@(posedge clk) disable iff (reset)
      $changed(adc_din) |-> $fell(adc_sclk))
    else begin
      fails++;
      $error("din changed away from a falling sclk edge");
    end

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
      outstanding <= adc_pkg::SAMPLE_CREDITS)
    else begin
      fails++;
      $error("more samples outstanding than credits");
    end

  a_half_period: assert property (@(posedge clk) disable iff (reset)
      (adc_sclk != sclk_q) && run_ok && (divide == div_q) |-> held == divide + 1)
    else begin
      fails++;
      $error("sclk half-period differs from divide+1");
    end

endmodule

`default_nettype wire

// File: dv/adc_chip_model.sv
// Behavioral serial ADC for the testbench
// Captures din in every frame and returns the tagged word given on next_word
`timescale 1ns/10ps
`default_nettype none

module adc_chip_model (
  input  logic adc_sclk,
  input  logic cs,
  input  logic adc_din,
  output logic adc_dout,
  input  adc_pkg::word_t next_word
);

  adc_pkg::word_t tx;
  adc_pkg::word_t rx;
  // Word captured from din in the most recent frame
  adc_pkg::word_t rx_last;
  int bit_idx;
  // Every word ever returned, indexed by the word itself
  bit sent_map [0:65535];

  initial begin
    adc_dout = 1'b0;
    tx = '0;
    rx = '0;
    rx_last = '0;
    bit_idx = 0;
  end

  // New frame, MSB goes out first
  always @(negedge cs) begin
    tx = next_word;
    sent_map[next_word] = 1'b1;
    rx = '0;
    bit_idx = 0;
    adc_dout = tx[15];
  end

  // DUT samples dout on this edge, so move on to the next bit right after
  always @(posedge adc_sclk) begin
    if (!cs) begin
      rx = {rx[14:0], adc_din};
      bit_idx = bit_idx + 1;
      if (bit_idx < adc_pkg::FRAME_BITS) begin
        adc_dout = tx[15 - bit_idx];
      end
    end
  end

  always @(posedge cs) begin
    rx_last = rx;
  end

endmodule

`default_nettype wire

// File: src/adc_control_top.sv
// Top level of the ADC control subsystem with plain bus, stream and ADC ports
`timescale 1ns/10ps
`default_nettype none

module adc_control_top (
  input  logic clk,
  input  logic reset,
  // Register bus
  input  adc_pkg::addr_t addr,
  input  adc_pkg::cmd_t data_in,
  input  logic enable,
  input  logic re,
  input  logic wr,
  output adc_pkg::word_t data_out,
  // Sample stream
  output logic sample_valid,
  output adc_pkg::chan_t sample_chan,
  output logic [adc_pkg::SEQ_W+adc_pkg::WORD_W-1:0] sample_data,
  input  logic sample_credit,
  // ADC pins
  output logic adc_sclk,
  output logic cs,
  output logic adc_din,
  input  logic adc_dout
);

  adc_cmd_if cmd ();

  adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] overflow;
  adc_pkg::chan_t rd_chan;
  adc_pkg::word_t rd_sample;
  adc_pkg::seq_t rd_seq;
  adc_pkg::word_t drops;
  adc_pkg::word_t word;
  logic word_valid;
  logic pub_valid;
  adc_pkg::chan_t pub_chan;
  adc_pkg::seq_t pub_seq;
  adc_pkg::word_t pub_word;

  adc_reg_bank u_reg_bank (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .data_in   (data_in),
    .enable    (enable),
    .re        (re),
    .wr        (wr),
    .data_out  (data_out),
    .cmd       (cmd.reg_side),
    .overflow  (overflow),
    .rd_chan   (rd_chan),
    .rd_sample (rd_sample),
    .rd_seq    (rd_seq),
    .drops     (drops)
  );

  adc_serial_engine u_serial_engine (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd.engine_side),
    .adc_sclk   (adc_sclk),
    .cs         (cs),
    .adc_din    (adc_din),
    .adc_dout   (adc_dout),
    .word       (word),
    .word_valid (word_valid)
  );

  adc_rate_decimator u_rate_decimator (
    .clk        (clk),
    .reset      (reset),
    .word       (word),
    .word_valid (word_valid),
    .overflow   (overflow),
    .rd_chan    (rd_chan),
    .rd_sample  (rd_sample),
    .rd_seq     (rd_seq),
    .pub_valid  (pub_valid),
    .pub_chan   (pub_chan),
    .pub_seq    (pub_seq),
    .pub_word   (pub_word)
  );

  adc_sample_stream u_sample_stream (
    .clk           (clk),
    .reset         (reset),
    .pub_valid     (pub_valid),
    .pub_chan      (pub_chan),
    .pub_seq       (pub_seq),
    .pub_word      (pub_word),
    .sample_valid  (sample_valid),
    .sample_chan   (sample_chan),
    .sample_data   (sample_data),
    .sample_credit (sample_credit),
    .drops         (drops)
  );

endmodule

`default_nettype wire

// File: src/adc_sample_stream.sv
// Credited sample stream with a small queue and a drop counter
// Each delivered sample spends one credit, each sample_credit pulse returns one
`timescale 1ns/10ps
`default_nettype none

module adc_sample_stream (
  input  logic clk,
  input  logic reset,
  input  logic pub_valid,
  input  adc_pkg::chan_t pub_chan,
  input  adc_pkg::seq_t pub_seq,
  input  adc_pkg::word_t pub_word,
  output logic sample_valid,
  output adc_pkg::chan_t sample_chan,
  output logic [adc_pkg::SEQ_W+adc_pkg::WORD_W-1:0] sample_data,
  input  logic sample_credit,
  output adc_pkg::word_t drops
);

  logic [adc_pkg::ENTRY_W-1:0] queue [adc_pkg::SAMPLE_CREDITS];
  logic [adc_pkg::PTR_W-1:0] wr_ptr;
  logic [adc_pkg::PTR_W-1:0] rd_ptr;
  logic [adc_pkg::CREDIT_W-1:0] count;
  logic [adc_pkg::CREDIT_W-1:0] credits;
  logic full;
  logic push;
  logic pop;

  assign full = (count == adc_pkg::CREDIT_W'(adc_pkg::SAMPLE_CREDITS));
  assign push = pub_valid && !full;
  // Deliver only while the consumer holds a credit
  assign pop = (count != '0) && (credits != '0);

  // ------------------------------------------------
  // Queue pointers, credits and drop count
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= adc_pkg::CREDIT_W'(adc_pkg::SAMPLE_CREDITS);
      sample_valid <= 1'b0;
      drops <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + adc_pkg::CREDIT_W'(push) - adc_pkg::CREDIT_W'(pop);
      credits <= credits - adc_pkg::CREDIT_W'(pop) + adc_pkg::CREDIT_W'(sample_credit);
      sample_valid <= pop;
      // Saturates at all ones
      if (pub_valid && full && (drops != '1)) begin
        drops <= drops + 1'b1;
      end
    end
  end

  // Queue storage and outgoing payload
  always_ff @(posedge clk) begin
    if (push) begin
      queue[wr_ptr] <= {pub_chan, pub_seq, pub_word};
    end
    if (pop) begin
      {sample_chan, sample_data} <= queue[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: src/adc_rate_decimator.sv
// Per-channel rate decimator with sequence numbers
// Latest words are published every overflow clocks, lowest channel served first
`timescale 1ns/10ps
`default_nettype none

module adc_rate_decimator (
  input  logic clk,
  input  logic reset,
  input  adc_pkg::word_t word,
  input  logic word_valid,
  input  adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] overflow,
  input  adc_pkg::chan_t rd_chan,
  output adc_pkg::word_t rd_sample,
  output adc_pkg::seq_t rd_seq,
  output logic pub_valid,
  output adc_pkg::chan_t pub_chan,
  output adc_pkg::seq_t pub_seq,
  output adc_pkg::word_t pub_word
);

  adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] hold;
  adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] sample;
  adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] cnt;
  adc_pkg::seq_t [adc_pkg::NUM_CHANNELS-1:0] seq;
  logic [adc_pkg::NUM_CHANNELS-1:0] seen;
  logic [adc_pkg::NUM_CHANNELS-1:0] wrap;
  logic [adc_pkg::NUM_CHANNELS-1:0] fire;
  logic [adc_pkg::NUM_CHANNELS-1:0] req;
  logic [adc_pkg::NUM_CHANNELS-1:0] served;
  adc_pkg::chan_t pick;
  adc_pkg::chan_t tag;

  // Channel tag of the incoming conversion word
  assign tag = word[adc_pkg::WORD_CHAN_LSB +: adc_pkg::CHAN_W];

  always_ff @(posedge clk) begin
    if (word_valid) begin
      hold[tag] <= word;
    end
  end

  // A channel publishes only once a word has arrived for it
  always_ff @(posedge clk) begin
    if (reset) begin
      seen <= '0;
    end else if (word_valid) begin
      seen[tag] <= 1'b1;
    end
  end

  // ------------------------------------------------
  // Interval counters, zero overflow holds a channel off
  // ------------------------------------------------
  for (genvar i = 0; i < adc_pkg::NUM_CHANNELS; i++) begin : g_chan
    assign wrap[i] = (overflow[i] != '0) && (cnt[i] >= overflow[i] - 1'b1);
    assign fire[i] = wrap[i] && seen[i];

    always_ff @(posedge clk) begin
      if (reset) begin
        cnt[i] <= '0;
        seq[i] <= '0;
        sample[i] <= '0;
      end else if (overflow[i] == '0) begin
        cnt[i] <= '0;
      end else if (wrap[i]) begin
        cnt[i] <= '0;
        if (seen[i]) begin
          sample[i] <= hold[i];
          seq[i] <= seq[i] + 1'b1;
        end
      end else begin
        cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  assign rd_sample = sample[rd_chan];
  assign rd_seq = seq[rd_chan];

  // ------------------------------------------------
  // Publish arbiter
  // ------------------------------------------------
  always_comb begin
    pick = '0;
    for (int i = adc_pkg::NUM_CHANNELS - 1; i >= 0; i--) begin
      if (req[i]) begin
        pick = adc_pkg::chan_t'(i);
      end
    end
  end

  assign served = (|req) ? (adc_pkg::NUM_CHANNELS'(1) << pick) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= '0;
      pub_valid <= 1'b0;
    end else begin
      // A fresh overflow keeps the request even when served now
      req <= (req & ~served) | fire;
      pub_valid <= |req;
    end
  end

  always_ff @(posedge clk) begin
    pub_chan <= pick;
    pub_seq <= seq[pick];
    pub_word <= sample[pick];
  end

endmodule

`default_nettype wire

// File: src/adc_serial_engine.sv
// Serial clock divider and chip-select frame engine for the ADC
// Runs program frames for pending commands and conversion frames otherwise
`timescale 1ns/10ps
`default_nettype none

module adc_serial_engine (
  input  logic clk,
  input  logic reset,
  adc_cmd_if.engine_side cmd,
  output logic adc_sclk,
  output logic cs,
  output logic adc_din,
  input  logic adc_dout,
  output adc_pkg::word_t word,
  output logic word_valid
);

  adc_pkg::frame_state_t state;
  adc_pkg::word_t div_cnt;
  logic tick;
  logic rise;
  logic fall;
  logic in_frame;
  logic frame_start;
  logic frame_last;
  logic [adc_pkg::BIT_CNT_W-1:0] bit_cnt;
  adc_pkg::word_t shift_reg;

  // ------------------------------------------------
  // Serial clock divider
  // ------------------------------------------------
  // Toggle every divide+1 clocks, also when divide shrinks mid-count
  assign tick = (div_cnt >= cmd.divide);
  assign rise = tick && !adc_sclk;
  assign fall = tick && adc_sclk;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      adc_sclk <= 1'b0;
    end else if (tick) begin
      div_cnt <= '0;
      adc_sclk <= !adc_sclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ------------------------------------------------
  // Frame control
  // ------------------------------------------------
  assign in_frame = (state == adc_pkg::program_frame) || (state == adc_pkg::convert_frame);
  // Frames begin and end on falling sclk edges
  assign frame_start = fall && !in_frame;
  assign frame_last = fall && in_frame &&
                      (bit_cnt == adc_pkg::BIT_CNT_W'(adc_pkg::FRAME_BITS - 1));

  assign cmd.cmd_taken = frame_start && cmd.cmd_pending;
  assign cmd.busy = cmd.cmd_pending || (state == adc_pkg::program_frame);

  assign cs = !in_frame;
  // din only carries data inside a program frame
  assign adc_din = (state == adc_pkg::program_frame) && shift_reg[adc_pkg::WORD_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= adc_pkg::idle;
      bit_cnt <= '0;
      word_valid <= 1'b0;
      cmd.last_cmd <= '0;
    end else begin
      word_valid <= 1'b0;
      if (frame_start) begin
        // Pending command takes the frame, otherwise convert
        state <= cmd.cmd_pending ? adc_pkg::program_frame : adc_pkg::convert_frame;
        bit_cnt <= '0;
      end else if (frame_last) begin
        // One sclk period of cs high before the next frame
        state <= adc_pkg::gap;
        word_valid <= (state == adc_pkg::convert_frame);
        if (state == adc_pkg::program_frame) begin
          // Sixteen rotations bring the command word back in place
          cmd.last_cmd <= {shift_reg[adc_pkg::WORD_W-2:0], shift_reg[adc_pkg::WORD_W-1]};
        end
      end else if (fall && in_frame) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Shift register, shared by both frame kinds
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (frame_start) begin
      shift_reg <= cmd.cmd_word;
    end else if (rise && (state == adc_pkg::convert_frame)) begin
      // dout sampled on the rising edge, MSB first
      shift_reg <= {shift_reg[adc_pkg::WORD_W-2:0], adc_dout};
    end else if (fall && (state == adc_pkg::program_frame)) begin
      // Rotate so the next bit reaches din after the falling edge
      shift_reg <= {shift_reg[adc_pkg::WORD_W-2:0], shift_reg[adc_pkg::WORD_W-1]};
    end
  end

  // Completed conversion word
  always_ff @(posedge clk) begin
    if (frame_last && (state == adc_pkg::convert_frame)) begin
      word <= shift_reg;
    end
  end

endmodule

`default_nettype wire

// File: src/adc_reg_bank.sv
// Bus decode, configuration registers and read-back mux
// Selector in addr[3:0], channel in addr[15:8]
`timescale 1ns/10ps
`default_nettype none

module adc_reg_bank (
  input  logic clk,
  input  logic reset,
  input  adc_pkg::addr_t addr,
  input  adc_pkg::cmd_t data_in,
  input  logic enable,
  input  logic re,
  input  logic wr,
  output adc_pkg::word_t data_out,
  adc_cmd_if.reg_side cmd,
  output adc_pkg::word_t [adc_pkg::NUM_CHANNELS-1:0] overflow,
  output adc_pkg::chan_t rd_chan,
  input  adc_pkg::word_t rd_sample,
  input  adc_pkg::seq_t rd_seq,
  input  adc_pkg::word_t drops
);

  adc_pkg::reg_sel_t sel;
  logic [adc_pkg::CHAN_FIELD_W-1:0] chan_field;
  logic chan_ok;
  logic wr_en;
  logic rd_en;
  logic prog_wr;
  adc_pkg::word_t rd_data;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign sel = addr[3:0];
  assign chan_field = addr[adc_pkg::CHAN_FIELD_LSB +: adc_pkg::CHAN_FIELD_W];
  // Channels past the last one are not decoded at all
  assign chan_ok = (chan_field < adc_pkg::NUM_CHANNELS);
  assign rd_chan = chan_field[adc_pkg::CHAN_W-1:0];

  assign wr_en = enable && wr && chan_ok;
  assign rd_en = enable && re && chan_ok;

  // Only the new-value opcode starts a program frame
  assign prog_wr = wr_en && (sel == adc_pkg::REG_PROGRAM) &&
                   (data_in[adc_pkg::CMD_W-1:adc_pkg::WORD_W] == adc_pkg::CMD_NEW_VALUE);

  // ------------------------------------------------
  // Configuration and command registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= '0;
      cmd.divide <= '0;
      cmd.cmd_pending <= 1'b0;
    end else begin
      if (wr_en && (sel == adc_pkg::REG_OVERFLOW)) begin
        overflow[rd_chan] <= data_in[adc_pkg::WORD_W-1:0];
      end
      if (wr_en && (sel == adc_pkg::REG_DIVIDE)) begin
        cmd.divide <= data_in[adc_pkg::WORD_W-1:0];
      end
      // A new write wins over a take in the same cycle
      if (prog_wr) begin
        cmd.cmd_pending <= 1'b1;
      end else if (cmd.cmd_taken) begin
        cmd.cmd_pending <= 1'b0;
      end
    end
  end

  // Pending word, overwritten by a later program write
  always_ff @(posedge clk) begin
    if (prog_wr) begin
      cmd.cmd_word <= data_in[adc_pkg::WORD_W-1:0];
    end
  end

  // ------------------------------------------------
  // Read-back
  // ------------------------------------------------
  always_comb begin
    rd_data = '0;
    case (sel)
      adc_pkg::REG_OVERFLOW: rd_data = overflow[rd_chan];
      adc_pkg::REG_DIVIDE:   rd_data = cmd.divide;
      adc_pkg::REG_SAMPLE:   rd_data = rd_sample;
      adc_pkg::REG_SEQUENCE: rd_data = rd_seq;
      adc_pkg::REG_ID:       rd_data = adc_pkg::ID_VALUE;
      adc_pkg::REG_BUSY:     rd_data = adc_pkg::word_t'(cmd.busy);
      adc_pkg::REG_LAST:     rd_data = cmd.last_cmd;
      adc_pkg::REG_DROPS:    rd_data = drops;
      default:               rd_data = '0;
    endcase
  end

  // Data one cycle after the read strobe, zero otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      data_out <= rd_en ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

// File: src/adc_cmd_if.sv
// Command and status link between the register bank and the serial engine
`timescale 1ns/10ps
`default_nettype none

interface adc_cmd_if;

  // Driven by the register bank
  adc_pkg::word_t cmd_word;
  logic cmd_pending;
  adc_pkg::word_t divide;

  // Driven by the serial engine
  logic cmd_taken;
  logic busy;
  adc_pkg::word_t last_cmd;

  modport reg_side (
    output cmd_word,
    output cmd_pending,
    output divide,
    input  cmd_taken,
    input  busy,
    input  last_cmd
  );

  modport engine_side (
    input  cmd_word,
    input  cmd_pending,
    input  divide,
    output cmd_taken,
    output busy,
    output last_cmd
  );

endinterface

`default_nettype wire

// File: src/adc_pkg.sv
// Shared widths, register map and constants of the ADC control subsystem
// Design files refer to these by scoped names
`default_nettype none

package adc_pkg;

  // Channel count and basic widths
  localparam int NUM_CHANNELS = 8;
  localparam int CHAN_W = 3;
  localparam int WORD_W = 16;
  localparam int SEQ_W = 16;
  localparam int ADDR_W = 16;
  localparam int CMD_W = 32;

  typedef logic [CHAN_W-1:0] chan_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [SEQ_W-1:0] seq_t;
  typedef logic [ADDR_W-1:0] addr_t;
  // Opcode in the upper half, ADC word in the lower half
  typedef logic [CMD_W-1:0] cmd_t;
  typedef logic [3:0] reg_sel_t;

  localparam logic [CMD_W-WORD_W-1:0] CMD_NEW_VALUE = 16'h0001;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  // Channel field of the bus address
  localparam int CHAN_FIELD_LSB = 8;
  localparam int CHAN_FIELD_W = 8;

  localparam reg_sel_t REG_OVERFLOW = 4'h1;
  localparam reg_sel_t REG_DIVIDE = 4'h2;
  localparam reg_sel_t REG_PROGRAM = 4'h4;
  localparam reg_sel_t REG_SAMPLE = 4'h7;
  localparam reg_sel_t REG_SEQUENCE = 4'h8;
  localparam reg_sel_t REG_ID = 4'h9;
  localparam reg_sel_t REG_BUSY = 4'hA;
  localparam reg_sel_t REG_LAST = 4'hB;
  localparam reg_sel_t REG_DROPS = 4'hC;

  localparam word_t ID_VALUE = 16'h0ADC;

  // Serial frame and conversion word tag
  localparam int FRAME_BITS = 16;
  localparam int BIT_CNT_W = $clog2(FRAME_BITS);
  localparam int WORD_CHAN_LSB = 13;

  // Queue depth equals the credits the consumer starts with
  localparam int SAMPLE_CREDITS = 4;
  localparam int CREDIT_W = $clog2(SAMPLE_CREDITS + 1);
  localparam int PTR_W = $clog2(SAMPLE_CREDITS);
  localparam int ENTRY_W = CHAN_W + SEQ_W + WORD_W;

  typedef enum logic [1:0] {
    idle,
    program_frame,
    convert_frame,
    gap
  } frame_state_t;

endpackage

`default_nettype wire
